// ==== source/id_branch_unit.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_branch_unit import la_id_pkg::*; (
    input  br_kind_e            br_kind,
    input  logic [`LA_XLEN-1:0] rj_value,
    input  logic [`LA_XLEN-1:0] rkd_value,
    input  logic [`LA_XLEN-1:0] pc,
    input  logic [`LA_XLEN-1:0] br_offs,
    output logic                br_cond,
    output logic [`LA_XLEN-1:0] br_target
);
    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    always_comb begin
        case (br_kind)
            BR_JIRL, BR_B: br_cond = 1'b1;
            BR_BEQ:        br_cond = eq;
            BR_BNE:        br_cond = !eq;
            BR_BLT:        br_cond = lt_s;
            BR_BGE:        br_cond = !lt_s;
            BR_BLTU:       br_cond = lt_u;
            BR_BGEU:       br_cond = !lt_u;
            default:       br_cond = 1'b0;
        endcase
    end

    // jirl is register relative
    assign br_target = ((br_kind == BR_JIRL) ? rj_value : pc) + br_offs;

endmodule

// ==== source/id_decoder.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_decoder import la_id_pkg::*; (
    input  logic [`LA_XLEN-1:0]     inst,
    output logic [`LA_ALU_OP_W-1:0] alu_op,
    output mem_type_t               mem_type,
    output logic                    mem_we,
    output logic                    res_from_mem,
    output logic                    gr_we,
    output reg_idx_t                dest,
    output reg_idx_t                rj,
    output reg_idx_t                rk_or_rd,
    output logic                    use_rj,
    output logic                    use_rkd,
    output logic                    src1_is_pc,
    output logic                    src2_is_imm,
    output logic [`LA_XLEN-1:0]     imm,
    output br_kind_e                br_kind,
    output logic [`LA_XLEN-1:0]     br_offs
);
    logic [16:0] op_31_15;
    logic [ 9:0] op_31_22;
    logic [ 6:0] op_31_25;
    logic [ 5:0] op_31_26;
    reg_idx_t    rd;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic [`LA_ALU_OP_W-1:0] op_3r;
    logic [`LA_ALU_OP_W-1:0] op_sh;
    logic [`LA_ALU_OP_W-1:0] op_i12;
    logic is_ld, is_st, is_ui12, is_si12, is_si20;
    logic is_lu12i, is_pcadd, is_bl, is_jirl, is_cbr, is_link;

    function automatic logic [`LA_ALU_OP_W-1:0] hot(input alu_op_e idx);
        logic [`LA_ALU_OP_W-1:0] v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    assign op_31_15 = inst[31:15];
    assign op_31_22 = inst[31:22];
    assign op_31_25 = inst[31:25];
    assign op_31_26 = inst[31:26];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        op_3r = '0;
        op_sh = '0;
        case (op_31_15)
            `LA_OP_ADD_W:  op_3r = hot(ALU_ADD);
            `LA_OP_SUB_W:  op_3r = hot(ALU_SUB);
            `LA_OP_SLT:    op_3r = hot(ALU_SLT);
            `LA_OP_SLTU:   op_3r = hot(ALU_SLTU);
            `LA_OP_NOR:    op_3r = hot(ALU_NOR);
            `LA_OP_AND:    op_3r = hot(ALU_AND);
            `LA_OP_OR:     op_3r = hot(ALU_OR);
            `LA_OP_XOR:    op_3r = hot(ALU_XOR);
            `LA_OP_SLL_W:  op_3r = hot(ALU_SLL);
            `LA_OP_SRL_W:  op_3r = hot(ALU_SRL);
            `LA_OP_SRA_W:  op_3r = hot(ALU_SRA);
            `LA_OP_SLLI_W: op_sh = hot(ALU_SLL);
            `LA_OP_SRLI_W: op_sh = hot(ALU_SRL);
            `LA_OP_SRAI_W: op_sh = hot(ALU_SRA);
            default: ;
        endcase
    end

    always_comb begin
        op_i12 = '0;
        case (op_31_22)
            `LA_OP_ADDI_W: op_i12 = hot(ALU_ADD);
            `LA_OP_SLTI:   op_i12 = hot(ALU_SLT);
            `LA_OP_SLTUI:  op_i12 = hot(ALU_SLTU);
            `LA_OP_ANDI:   op_i12 = hot(ALU_AND);
            `LA_OP_ORI:    op_i12 = hot(ALU_OR);
            `LA_OP_XORI:   op_i12 = hot(ALU_XOR);
            default: ;
        endcase
    end

    always_comb begin
        case (op_31_22)
            `LA_OP_LD_H, `LA_OP_ST_H: mem_type = MEM_H;
            `LA_OP_LD_B, `LA_OP_ST_B: mem_type = MEM_B;
            `LA_OP_LD_HU:             mem_type = MEM_HU;
            `LA_OP_LD_BU:             mem_type = MEM_BU;
            default:                  mem_type = MEM_W;
        endcase
    end

    always_comb begin
        case (op_31_26)
            `LA_OP_JIRL:      br_kind = BR_JIRL;
            `LA_OP_B, `LA_OP_BL: br_kind = BR_B;
            `LA_OP_BEQ:       br_kind = BR_BEQ;
            `LA_OP_BNE:       br_kind = BR_BNE;
            `LA_OP_BLT:       br_kind = BR_BLT;
            `LA_OP_BGE:       br_kind = BR_BGE;
            `LA_OP_BLTU:      br_kind = BR_BLTU;
            `LA_OP_BGEU:      br_kind = BR_BGEU;
            default:          br_kind = BR_NONE;
        endcase
    end

    assign is_ld = op_31_22 inside {`LA_OP_LD_B, `LA_OP_LD_H, `LA_OP_LD_W,
                                    `LA_OP_LD_BU, `LA_OP_LD_HU};
    assign is_st = op_31_22 inside {`LA_OP_ST_B, `LA_OP_ST_H, `LA_OP_ST_W};
    assign is_ui12  = op_31_22 inside {`LA_OP_ANDI, `LA_OP_ORI, `LA_OP_XORI};
    assign is_si12  = (|op_i12 & ~is_ui12) | is_ld | is_st;
    assign is_lu12i = op_31_25 == `LA_OP_LU12I_W;
    assign is_pcadd = op_31_25 == `LA_OP_PCADDU12I;
    assign is_si20  = is_lu12i | is_pcadd;
    assign is_bl    = op_31_26 == `LA_OP_BL;
    assign is_jirl  = br_kind == BR_JIRL;
    assign is_cbr   = br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    assign is_link  = is_jirl | is_bl; // writes pc + 4

    assign alu_op = op_3r | op_sh | op_i12
                  | (is_lu12i ? hot(ALU_LUI) : '0)
                  | (is_ld | is_st | is_link | is_pcadd ? hot(ALU_ADD) : '0);

    assign mem_we       = is_st;
    assign res_from_mem = is_ld;
    assign gr_we        = |alu_op & ~is_st; // b and conditional branches carry no op
    assign dest         = is_bl ? reg_idx_t'(1) : rd;

    assign rk_or_rd    = (is_st | is_cbr) ? rd : rk;
    assign use_rj      = |op_3r | |op_sh | |op_i12 | is_ld | is_st | is_jirl | is_cbr;
    assign use_rkd     = |op_3r | is_st | is_cbr;
    assign src1_is_pc  = is_link | is_pcadd;
    assign src2_is_imm = |op_sh | is_si12 | is_ui12 | is_si20 | is_link;

    assign imm = is_link ? `LA_XLEN'(4)               :
                 is_si20 ? {i20, 12'b0}               :
                 |op_sh  ? {{(`LA_XLEN-5){1'b0}}, rk}  :
                 is_si12 ? {{(`LA_XLEN-12){i12[11]}}, i12} :
                 is_ui12 ? {{(`LA_XLEN-12){1'b0}}, i12}    :
                 '0;

    // offs26 for b/bl, offs16 otherwise
    assign br_offs = (br_kind == BR_B) ? {{4{i26[25]}}, i26, 2'b0}
                                       : {{14{i16[15]}}, i16, 2'b0};

endmodule

// ==== source/id_operand_fwd.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_operand_fwd import la_id_pkg::*; (
    input  reg_idx_t            rj,
    input  reg_idx_t            rk_or_rd,
    input  logic                use_rj,
    input  logic                use_rkd,
    input  logic [`LA_XLEN-1:0] rf_rdata1,
    input  logic [`LA_XLEN-1:0] rf_rdata2,
    input  logic                ex_fwd_valid,
    input  logic                ex_is_load,
    input  reg_idx_t            ex_dest,
    input  logic [`LA_XLEN-1:0] ex_wdata,
    input  logic                mem_fwd_valid,
    input  reg_idx_t            mem_dest,
    input  logic [`LA_XLEN-1:0] mem_wdata,
    input  logic                wb_we,
    input  reg_idx_t            wb_waddr,
    input  logic [`LA_XLEN-1:0] wb_wdata,
    output reg_idx_t            rf_raddr1,
    output reg_idx_t            rf_raddr2,
    output logic [`LA_XLEN-1:0] rj_value,
    output logic [`LA_XLEN-1:0] rkd_value,
    output logic                load_use_stall
);
    logic hit_ex_rj;
    logic hit_ex_rkd;

    // youngest producer wins, r0 always from the file
    function automatic logic [`LA_XLEN-1:0] pick(input reg_idx_t idx,
                                                input logic [`LA_XLEN-1:0] rf_val);
        if (idx == '0)
            return rf_val;
        if (ex_fwd_valid && ex_dest == idx)
            return ex_wdata;
        if (mem_fwd_valid && mem_dest == idx)
            return mem_wdata;
        if (wb_we && wb_waddr == idx)
            return wb_wdata;
        return rf_val;
    endfunction

    assign rf_raddr1 = rj;
    assign rf_raddr2 = rk_or_rd;

    always_comb begin
        rj_value  = pick(rj, rf_rdata1);
        rkd_value = pick(rk_or_rd, rf_rdata2);
    end

    assign hit_ex_rj  = use_rj  && rj == ex_dest;
    assign hit_ex_rkd = use_rkd && rk_or_rd == ex_dest;

    // load data not back until mem
    assign load_use_stall = ex_fwd_valid && ex_is_load && ex_dest != '0
                         && (hit_ex_rj || hit_ex_rkd);

endmodule

// ==== source/id_regfile.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_regfile import la_id_pkg::*; (
    input  logic                clk,
    input  reg_idx_t            raddr1,
    input  reg_idx_t            raddr2,
    input  logic                we,
    input  reg_idx_t            waddr,
    input  logic [`LA_XLEN-1:0] wdata,
    output logic [`LA_XLEN-1:0] rdata1,
    output logic [`LA_XLEN-1:0] rdata2
);
    logic [`LA_XLEN-1:0] rf [`LA_NREG];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_stage import la_id_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    if_id_valid,
    output logic                    id_allowin,
    input  logic [`LA_XLEN-1:0]     if_inst,
    input  logic [`LA_XLEN-1:0]     if_pc,
    output logic                    id_ex_valid,
    input  logic                    ex_allowin,
    output logic [`LA_ALU_OP_W-1:0] alu_op,
    output logic [`LA_XLEN-1:0]     alu_src1,
    output logic [`LA_XLEN-1:0]     alu_src2,
    output logic [`LA_XLEN-1:0]     store_data,
    output logic [`LA_XLEN-1:0]     ex_pc,
    output mem_type_t               mem_type,
    output logic                    mem_we,
    output logic                    res_from_mem,
    output logic                    gr_we,
    output reg_idx_t                dest,
    output logic                    br_taken,
    output logic [`LA_XLEN-1:0]     br_target,
    input  logic                    ex_fwd_valid,
    input  logic                    ex_is_load,
    input  reg_idx_t                ex_dest,
    input  logic [`LA_XLEN-1:0]     ex_wdata,
    input  logic                    mem_fwd_valid,
    input  reg_idx_t                mem_dest,
    input  logic [`LA_XLEN-1:0]     mem_wdata,
    input  logic                    wb_we,
    input  reg_idx_t                wb_waddr,
    input  logic [`LA_XLEN-1:0]     wb_wdata
);
    logic [`LA_XLEN-1:0] inst, pc;
    logic [`LA_XLEN-1:0] imm, br_offs;
    logic [`LA_XLEN-1:0] rf_rdata1, rf_rdata2;
    logic [`LA_XLEN-1:0] rj_value, rkd_value;
    reg_idx_t            rj, rk_or_rd, rf_raddr1, rf_raddr2;
    logic                use_rj, use_rkd, src1_is_pc, src2_is_imm;
    logic                load_use_stall, br_cond;
    br_kind_e            br_kind;

    id_stage_ctrl u_ctrl (
        .clk, .resetn, .if_id_valid, .if_inst, .if_pc, .ex_allowin,
        .load_use_stall, .br_cond,
        .id_allowin, .id_ex_valid, .br_taken, .inst, .pc
    );

    id_decoder u_dec (
        .inst, .alu_op, .mem_type, .mem_we, .res_from_mem, .gr_we, .dest,
        .rj, .rk_or_rd, .use_rj, .use_rkd, .src1_is_pc, .src2_is_imm,
        .imm, .br_kind, .br_offs
    );

    id_regfile u_rf (
        .clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    id_operand_fwd u_fwd (
        .rj, .rk_or_rd, .use_rj, .use_rkd, .rf_rdata1, .rf_rdata2,
        .ex_fwd_valid, .ex_is_load, .ex_dest, .ex_wdata,
        .mem_fwd_valid, .mem_dest, .mem_wdata, .wb_we, .wb_waddr, .wb_wdata,
        .rf_raddr1, .rf_raddr2, .rj_value, .rkd_value, .load_use_stall
    );

    id_branch_unit u_br (
        .br_kind, .rj_value, .rkd_value, .pc, .br_offs, .br_cond, .br_target
    );

    assign alu_src1   = src1_is_pc ? pc : rj_value;
    assign alu_src2   = src2_is_imm ? imm : rkd_value;
    assign store_data = rkd_value; // rd of a store
    assign ex_pc      = pc;

endmodule

// ==== source/id_stage_ctrl.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_stage_ctrl import la_id_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                if_id_valid,
    input  logic [`LA_XLEN-1:0] if_inst,
    input  logic [`LA_XLEN-1:0] if_pc,
    input  logic                ex_allowin,
    input  logic                load_use_stall,
    input  logic                br_cond,
    output logic                id_allowin,
    output logic                id_ex_valid,
    output logic                br_taken,
    output logic [`LA_XLEN-1:0] inst,
    output logic [`LA_XLEN-1:0] pc
);
    logic id_valid;
    logic id_ready_go;
    logic id_leave;

    assign id_ready_go = !load_use_stall;
    assign id_ex_valid = id_valid && id_ready_go;
    assign id_leave    = id_ex_valid && ex_allowin;
    assign id_allowin  = !id_valid || id_leave;
    assign br_taken    = br_cond && id_leave; // one cycle redirect to fetch

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0; // wrong-path fetch dropped
        end else if (id_allowin) begin
            id_valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken) begin
            inst <= INST_NOP; // park a nop so decode stays quiet
        end else if (if_id_valid && id_allowin) begin
            inst <= if_inst;
            pc   <= if_pc;
        end
    end

endmodule

// ==== source/la_id_defs.svh ====
`ifndef LA_ID_DEFS_SVH
`define LA_ID_DEFS_SVH

`define LA_XLEN      32
`define LA_NREG      32
`define LA_ALU_OP_W  12

// inst[31:15], 3r and shift by immediate
`define LA_OP_ADD_W      17'h00020
`define LA_OP_SUB_W      17'h00022
`define LA_OP_SLT        17'h00024
`define LA_OP_SLTU       17'h00025
`define LA_OP_NOR        17'h00028
`define LA_OP_AND        17'h00029
`define LA_OP_OR         17'h0002a
`define LA_OP_XOR        17'h0002b
`define LA_OP_SLL_W      17'h0002e
`define LA_OP_SRL_W      17'h0002f
`define LA_OP_SRA_W      17'h00030
`define LA_OP_SLLI_W     17'h00081
`define LA_OP_SRLI_W     17'h00089
`define LA_OP_SRAI_W     17'h00091

// inst[31:22], 2ri12 forms
`define LA_OP_SLTI       10'h008
`define LA_OP_SLTUI      10'h009
`define LA_OP_ADDI_W     10'h00a
`define LA_OP_ANDI       10'h00d
`define LA_OP_ORI        10'h00e
`define LA_OP_XORI       10'h00f
`define LA_OP_LD_B       10'h0a0
`define LA_OP_LD_H       10'h0a1
`define LA_OP_LD_W       10'h0a2
`define LA_OP_ST_B       10'h0a4
`define LA_OP_ST_H       10'h0a5
`define LA_OP_ST_W       10'h0a6
`define LA_OP_LD_BU      10'h0a8
`define LA_OP_LD_HU      10'h0a9

// inst[31:25], 1ri20
`define LA_OP_LU12I_W    7'h0a
`define LA_OP_PCADDU12I  7'h0e

// inst[31:26], jumps and branches
`define LA_OP_JIRL       6'h13
`define LA_OP_B          6'h14
`define LA_OP_BL         6'h15
`define LA_OP_BEQ        6'h16
`define LA_OP_BNE        6'h17
`define LA_OP_BLT        6'h18
`define LA_OP_BGE        6'h19
`define LA_OP_BLTU       6'h1a
`define LA_OP_BGEU       6'h1b

`endif

// ==== source/la_id_pkg.sv ====
`include "la_id_defs.svh"

package la_id_pkg;

    typedef logic [$clog2(`LA_NREG)-1:0] reg_idx_t;

    // bit positions in the one-hot alu_op
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef logic [2:0] mem_type_t;

    localparam mem_type_t MEM_W  = 3'b000;
    localparam mem_type_t MEM_H  = 3'b001;
    localparam mem_type_t MEM_B  = 3'b010;
    localparam mem_type_t MEM_HU = 3'b101; // zero extended
    localparam mem_type_t MEM_BU = 3'b110;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_JIRL,
        BR_B,    // b and bl
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_kind_e;

    localparam logic [`LA_XLEN-1:0] INST_NOP = 32'h0340_0000; // andi r0, r0, 0

endpackage

// ==== verif/id_stage_chk.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_stage_chk import la_id_pkg::*; (
    input logic                clk,
    input logic                resetn,
    input logic                id_ex_valid,
    input logic                ex_allowin,
    input logic                br_taken,
    input logic [`LA_XLEN-1:0] ex_pc
);
    int fail_count = 0;

    // stage register has seen at least one reset edge
    a_quiet_in_reset: assert property (
        @(posedge clk) (!resetn && $past(!resetn)) |-> !id_ex_valid
    ) else begin
        fail_count++;
        $error("id_ex_valid high during reset");
    end

    a_taken_leaves: assert property (
        @(posedge clk) disable iff (!resetn)
        br_taken |-> (id_ex_valid && ex_allowin)
    ) else begin
        fail_count++;
        $error("br_taken without the instruction leaving");
    end

    a_pc_holds: assert property (
        @(posedge clk) disable iff (!resetn)
        (id_ex_valid && !ex_allowin) |=> $stable(ex_pc)
    ) else begin
        fail_count++;
        $error("ex_pc changed under back-pressure");
    end

endmodule

// ==== verif/id_stage_clkgen.sv ====
`timescale 1ns/1ps

module id_stage_clkgen (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

// ==== verif/id_stage_tb.sv ====
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_stage_tb import la_id_pkg::*; ();
    localparam int NROWS = 28;
    localparam int TIMEOUT_CYCLES = 40 * NROWS;
    localparam int M_NONE = 0, M_FWD_A = 1, M_FWD_B = 2, M_FWD_R0 = 3;
    localparam int M_LOAD = 4, M_BP = 5, M_WRONG = 6;

    // fl bits from msb gr_we mem_we res_from_mem src1_pc src2_imm taken target_from_rj
    typedef struct packed {
        logic [31:0] inst;
        logic [4:0]  rja;
        logic [4:0]  rkda;
        logic [2:0]  mode;
        logic [31:0] vj;
        logic [31:0] vk;
        logic [11:0] op;
        logic [4:0]  dest;
        logic [6:0]  fl;
        logic [2:0]  mt;
        logic [31:0] imm;
        logic [31:0] offs;
    } case_t;

    logic clk, resetn;
    logic if_id_valid, id_allowin, id_ex_valid, ex_allowin;
    logic [31:0] if_inst, if_pc, alu_src1, alu_src2, store_data, ex_pc, br_target;
    logic [11:0] alu_op;
    mem_type_t mem_type;
    logic mem_we, res_from_mem, gr_we, br_taken;
    reg_idx_t dest, ex_dest, mem_dest, wb_waddr;
    logic ex_fwd_valid, ex_is_load, mem_fwd_valid, wb_we;
    logic [31:0] ex_wdata, mem_wdata, wb_wdata;

    case_t tbl [NROWS];
    int nrows = 0;
    int errors = 0;
    int cycles = 0;
    logic [31:0] lcg_state = 32'd29;

    id_stage_clkgen u_clkgen (.clk, .resetn);

    id_stage uut (.*);

    bind id_stage id_stage_chk u_chk (
        .clk, .resetn, .id_ex_valid, .ex_allowin, .br_taken, .ex_pc
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [11:0] one_hot(input int idx);
        return 12'b1 << idx;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [11:0] i,
                                            input logic [4:0] rj, rd);
        return {op, i, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i20(input logic [6:0] op, input logic [19:0] i,
                                            input logic [4:0] rd);
        return {op, i, rd};
    endfunction

    function automatic logic [31:0] enc_i16(input logic [5:0] op, input logic [15:0] o,
                                            input logic [4:0] rj, rd);
        return {op, o, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] o);
        return {op, o[15:0], o[25:16]};
    endfunction

    task automatic add_row(input logic [31:0] inst, input int rja, rkda, mode,
                           input logic [31:0] vj, vk, input logic [11:0] op, input int dest,
                           input logic [6:0] fl, input logic [2:0] mt,
                           input logic [31:0] imm, offs);
        tbl[nrows] = {inst, 5'(rja), 5'(rkda), 3'(mode), vj, vk, op, 5'(dest), fl, mt, imm, offs};
        nrows++;
    endtask

    task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic set_bypass(input logic ev, el, input int ed, input logic [31:0] ewd,
                              input logic mv, input int md, input logic [31:0] mwd,
                              input logic wv, input int wa, input logic [31:0] wd);
        ex_fwd_valid = ev;
        ex_is_load = el;
        ex_dest = 5'(ed);
        ex_wdata = ewd;
        mem_fwd_valid = mv;
        mem_dest = 5'(md);
        mem_wdata = mwd;
        wb_we = wv;
        wb_waddr = 5'(wa);
        wb_wdata = wd;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        case_t c;
        logic [31:0] pc, vj, vk, va, vb, vc, ej, ek;
        int row_start;

        if_id_valid = 0;
        if_inst = 0;
        if_pc = 0;
        ex_allowin = 1;
        set_bypass(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);

        add_row(enc_i12(`LA_OP_SLTI, 12'hffd, 5, 7), 5, 29, M_NONE, 0, 0,
                one_hot(ALU_SLT), 7, 7'b1000100, MEM_W, 32'hffff_fffd, 0);
        add_row(enc_i12(`LA_OP_ORI, 12'hf00, 5, 7), 5, 0, M_NONE, 0, 0,
                one_hot(ALU_OR), 7, 7'b1000100, MEM_W, 32'h0000_0f00, 0);
        add_row(enc_3r(`LA_OP_SRAI_W, 13, 5, 7), 5, 13, M_NONE, 0, 0,
                one_hot(ALU_SRA), 7, 7'b1000100, MEM_W, 32'd13, 0);
        add_row(enc_i20(`LA_OP_LU12I_W, 20'h80005, 7), 5, 0, M_NONE, 0, 0,
                one_hot(ALU_LUI), 7, 7'b1000100, MEM_W, 32'h8000_5000, 0);
        add_row(enc_i20(`LA_OP_PCADDU12I, 20'h00025, 7), 5, 0, M_NONE, 0, 0,
                one_hot(ALU_ADD), 7, 7'b1001100, MEM_W, 32'h0002_5000, 0);
        add_row(enc_i12(`LA_OP_LD_H, 12'hff8, 5, 7), 5, 30, M_NONE, 0, 0,
                one_hot(ALU_ADD), 7, 7'b1010100, MEM_H, 32'hffff_fff8, 0);
        add_row(enc_i12(`LA_OP_LD_BU, 12'h00c, 5, 7), 5, 3, M_NONE, 0, 0,
                one_hot(ALU_ADD), 7, 7'b1010100, MEM_BU, 32'd12, 0);
        add_row(enc_i12(`LA_OP_ST_W, 12'hffc, 5, 7), 5, 7, M_NONE, 0, 0,
                one_hot(ALU_ADD), 7, 7'b0100100, MEM_W, 32'hffff_fffc, 0);
        add_row(enc_3r(`LA_OP_ADD_W, 6, 5, 7), 5, 6, M_FWD_A, 0, 0,
                one_hot(ALU_ADD), 7, 7'b1000000, MEM_W, 0, 0);
        add_row(enc_3r(`LA_OP_ADD_W, 6, 5, 7), 5, 6, M_FWD_B, 0, 0,
                one_hot(ALU_ADD), 7, 7'b1000000, MEM_W, 0, 0);
        add_row(enc_3r(`LA_OP_ADD_W, 6, 0, 7), 0, 6, M_FWD_R0, 0, 0,
                one_hot(ALU_ADD), 7, 7'b1000000, MEM_W, 0, 0);
        add_row(enc_3r(`LA_OP_OR, 6, 5, 7), 5, 6, M_LOAD, 0, 0,
                one_hot(ALU_OR), 7, 7'b1000000, MEM_W, 0, 0);
        add_row(enc_3r(`LA_OP_XOR, 6, 5, 7), 5, 6, M_BP, 0, 0,
                one_hot(ALU_XOR), 7, 7'b1000000, MEM_W, 0, 0);
        add_row(enc_i16(`LA_OP_BEQ, 16'h0010, 5, 7), 5, 7, M_NONE, 32'h1234, 32'h1234,
                12'h0, 7, 7'b0000010, MEM_W, 0, 32'h40);
        add_row(enc_i16(`LA_OP_BEQ, 16'h0010, 5, 7), 5, 7, M_NONE, 32'h1234, 32'h1235,
                12'h0, 7, 7'b0000000, MEM_W, 0, 32'h40);
        add_row(enc_i16(`LA_OP_BNE, 16'hfff0, 5, 7), 5, 7, M_NONE, 32'h55aa, 32'h55aa,
                12'h0, 7, 7'b0000000, MEM_W, 0, 32'hffff_ffc0);
        add_row(enc_i16(`LA_OP_BNE, 16'hfff0, 5, 7), 5, 7, M_NONE, 32'h55aa, 32'h55ab,
                12'h0, 7, 7'b0000010, MEM_W, 0, 32'hffff_ffc0);
        add_row(enc_i16(`LA_OP_BLT, 16'h0008, 5, 7), 5, 7, M_NONE, 32'hffff_fff0, 32'd5,
                12'h0, 7, 7'b0000010, MEM_W, 0, 32'h20);
        add_row(enc_i16(`LA_OP_BLT, 16'h0008, 5, 7), 5, 7, M_NONE, 32'd5, 32'hffff_fff0,
                12'h0, 7, 7'b0000000, MEM_W, 0, 32'h20);
        add_row(enc_i16(`LA_OP_BGE, 16'h0008, 5, 7), 5, 7, M_NONE, 32'hffff_fff0, 32'd5,
                12'h0, 7, 7'b0000000, MEM_W, 0, 32'h20);
        add_row(enc_i16(`LA_OP_BGE, 16'h0008, 5, 7), 5, 7, M_NONE, 32'd5, 32'hffff_fff0,
                12'h0, 7, 7'b0000010, MEM_W, 0, 32'h20);
        add_row(enc_i16(`LA_OP_BLTU, 16'h0008, 5, 7), 5, 7, M_NONE, 32'hffff_fff0, 32'd5,
                12'h0, 7, 7'b0000000, MEM_W, 0, 32'h20);
        add_row(enc_i16(`LA_OP_BLTU, 16'h0008, 5, 7), 5, 7, M_NONE, 32'd5, 32'hffff_fff0,
                12'h0, 7, 7'b0000010, MEM_W, 0, 32'h20);
        add_row(enc_i16(`LA_OP_BGEU, 16'hfff0, 5, 7), 5, 7, M_NONE, 32'hffff_fff0, 32'd5,
                12'h0, 7, 7'b0000010, MEM_W, 0, 32'hffff_ffc0);
        add_row(enc_i16(`LA_OP_BGEU, 16'hfff0, 5, 7), 5, 7, M_NONE, 32'd5, 32'hffff_fff0,
                12'h0, 7, 7'b0000000, MEM_W, 0, 32'hffff_ffc0);
        add_row(enc_i16(`LA_OP_JIRL, 16'h0002, 5, 1), 5, 2, M_NONE, 32'h1c00_2000, 0,
                one_hot(ALU_ADD), 1, 7'b1001111, MEM_W, 32'd4, 32'h8);
        add_row(enc_i26(`LA_OP_B, 26'h0000100), 0, 0, M_WRONG, 0, 0,
                12'h0, 0, 7'b0000010, MEM_W, 0, 32'h400);
        add_row(enc_i26(`LA_OP_BL, 26'h3fffffc), 0, 0, M_NONE, 0, 0,
                one_hot(ALU_ADD), 1, 7'b1001110, MEM_W, 32'd4, 32'hffff_fff0);

        @(posedge resetn);
        @(posedge clk);
        #1;
        check("id_allowin", id_allowin, 1);
        check("id_ex_valid", id_ex_valid, 0);
        check("br_taken", br_taken, 0);

        for (int i = 0; i < nrows; i++) begin
            c = tbl[i];
            row_start = errors;
            pc = 32'h1c00_0000 + i * 64;
            vj = (c.vj != 0) ? c.vj : lcg_next();
            vk = (c.vk != 0) ? c.vk : lcg_next();
            va = lcg_next();
            vb = lcg_next();
            vc = lcg_next();
            ej = (c.rja == 0) ? 32'h0 : vj;
            ek = (c.rkda == 0) ? 32'h0 : vk;

            set_bypass(0, 0, 0, 0, 0, 0, 0, 1, c.rja, vj); // preload through wb
            @(posedge clk);
            #1;
            set_bypass(0, 0, 0, 0, 0, 0, 0, 1, c.rkda, vk);
            @(posedge clk);
            #1;
            set_bypass(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
            case (c.mode)
                M_FWD_A: begin
                    set_bypass(1, 0, c.rja, va, 1, c.rja, vb, 1, c.rkda, vc);
                    ej = va;
                    ek = vc;
                end
                M_FWD_B: begin
                    set_bypass(1, 0, c.rkda, va, 1, c.rja, vb, 1, c.rja, vc);
                    ej = vb;
                    ek = va;
                end
                M_FWD_R0: set_bypass(1, 0, 0, va, 1, 0, vb, 1, 0, vc);
                M_LOAD: begin
                    set_bypass(1, 1, c.rja, va, 0, 0, 0, 0, 0, 0);
                    ej = va;
                end
                M_BP: ex_allowin = 0;
                default: ;
            endcase

            if_id_valid = 1;
            if_inst = c.inst;
            if_pc = pc;
            do @(negedge clk); while (!id_allowin);
            @(posedge clk);
            #1;
            if_id_valid = 0;
            if (c.mode == M_WRONG) begin
                if_id_valid = 1; // wrong-path fetch offered beside the branch
                if_inst = enc_i12(`LA_OP_ADDI_W, 12'h001, 9, 9);
                if_pc = pc + 4;
            end

            if (c.mode == M_LOAD) begin
                repeat (3) begin
                    @(negedge clk);
                    check("id_ex_valid", id_ex_valid, 0);
                    @(posedge clk);
                    #1;
                end
                ex_is_load = 0;
            end
            if (c.mode == M_BP) begin
                if_id_valid = 1; // next fetch waits behind the held instruction
                if_inst = enc_i12(`LA_OP_ADDI_W, 12'h001, 9, 9);
                if_pc = pc + 4;
                repeat (4) begin
                    @(negedge clk);
                    check("id_allowin", id_allowin, 0);
                    check("id_ex_valid", id_ex_valid, 1);
                    check("ex_pc", ex_pc, pc);
                    check("alu_op", alu_op, c.op);
                    check("dest", dest, c.dest);
                end
                @(posedge clk);
                #1;
                if_id_valid = 0;
                ex_allowin = 1;
            end

            do @(negedge clk); while (!(id_ex_valid && ex_allowin));
            check("alu_op", alu_op, c.op);
            check("dest", dest, c.dest);
            check("gr_we", gr_we, c.fl[6]);
            check("mem_we", mem_we, c.fl[5]);
            check("res_from_mem", res_from_mem, c.fl[4]);
            check("mem_type", mem_type, c.mt);
            check("alu_src1", alu_src1, c.fl[3] ? pc : ej);
            check("alu_src2", alu_src2, c.fl[2] ? c.imm : ek);
            if (c.fl[5])
                check("store_data", store_data, ek);
            check("ex_pc", ex_pc, pc);
            check("br_taken", br_taken, c.fl[1]);
            if (c.fl[1])
                check("br_target", br_target, (c.fl[0] ? ej : pc) + c.offs);
            @(posedge clk);
            #1;
            if_id_valid = 0;
            set_bypass(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
            if (c.mode == M_WRONG) begin
                @(negedge clk);
                check("id_ex_valid", id_ex_valid, 0); // flushed so nothing delivered
            end
            $display("case %0d inst %h %s", i, c.inst,
                     (errors == row_start) ? "ok" : "mismatch");
        end

        errors += uut.u_chk.fail_count;
        $display("%0d cases run, %0d errors", nrows, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/la_id_pkg.sv
source/id_decoder.sv
source/id_regfile.sv
source/id_operand_fwd.sv
source/id_branch_unit.sv
source/id_stage_ctrl.sv
source/id_stage.sv
verif/id_stage_clkgen.sv
verif/id_stage_chk.sv
verif/id_stage_tb.sv
